// ==== hw/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath width
`define DATA_W 32

// register index width, index 15 is the non-register
`define REG_ADDR_W 4

// stored registers r0 to r14
`define NUM_REGS 15

// byte step between instruction words
`define PC_STEP 4

`endif

// ==== hw/core_pkg.sv ====
`include "core_params.svh"

package core_pkg;

    // values follow the cmd field of the instruction
    typedef enum logic [3:0] {
        ALU_AND = 4'd0,
        ALU_SUB = 4'd2,
        ALU_ADD = 4'd4,
        ALU_ORR = 4'd12,
        ALU_MOV = 4'd13
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;
        alu_op_t alu_op;
    } ctrl_t;

    // decode to execute, rm holds Rd for a store
    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`DATA_W-1:0]      rd1;
        logic [`DATA_W-1:0]      rd2;
        logic [11:0]             imm;
        logic [`REG_ADDR_W-1:0]  rn;
        logic [`REG_ADDR_W-1:0]  rm;
        logic [`REG_ADDR_W-1:0]  rd;
    } id_ex_t;

    typedef struct packed {
        logic                    reg_write;
        logic                    mem_write;
        logic                    mem_to_reg;
        logic [`DATA_W-1:0]      alu_result;
        logic [`DATA_W-1:0]      write_data;
        logic [`REG_ADDR_W-1:0]  rd;
    } ex_mem_t;

    typedef struct packed {
        logic                    reg_write;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`DATA_W-1:0]      result;
    } wb_t;

endpackage

// ==== hw/fetch_stage.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module fetch_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall,
    output logic [`DATA_W-1:0] pc
);

    // pc holds while a load-use bubble goes in
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + `DATA_W'(`PC_STEP);
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module reg_file import core_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] ra1,
    input  logic [`REG_ADDR_W-1:0] ra2,
    input  wb_t                    wb,
    output logic [`DATA_W-1:0]     rd1,
    output logic [`DATA_W-1:0]     rd2
);

    localparam logic [`REG_ADDR_W-1:0] NO_REG = `REG_ADDR_W'(`NUM_REGS);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    // write-through, so the write in this cycle is seen by decode
    function automatic logic [`DATA_W-1:0] read_port(input logic [`REG_ADDR_W-1:0] idx);
        logic [`DATA_W-1:0] value;
        if (idx == NO_REG) begin
            value = '0;
        end else if (wb.reg_write && wb.rd == idx) begin
            value = wb.result;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != NO_REG) begin
            regs[wb.rd] <= wb.result;
        end
    end

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

    // decode drops every write to r15 before it reaches writeback
    a_no_r15_write: assert property (@(posedge clk) disable iff (reset)
        wb.reg_write |-> wb.rd != NO_REG);

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module decode_stage import core_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic [`DATA_W-1:0]     instr,
    input  wb_t                    wb,
    output id_ex_t                 id_ex,
    output logic [`REG_ADDR_W-1:0] rn_d,
    output logic [`REG_ADDR_W-1:0] rm_d
);

    localparam logic [`REG_ADDR_W-1:0] NO_REG = `REG_ADDR_W'(`NUM_REGS);

    logic [`DATA_W-1:0]     instr_d;
    logic                   instr_valid;
    logic [1:0]             op;
    logic                   i_bit;
    logic                   l_bit;
    logic [3:0]             cmd;
    logic [`REG_ADDR_W-1:0] rn;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rm;
    ctrl_t                  ctrl;
    logic                   uses_rn;
    logic                   uses_rm;
    logic                   is_store;
    logic [`DATA_W-1:0]     rd1;
    logic [`DATA_W-1:0]     rd2;

    //////////////////////////////////////////////////////////////////////
    // fetch-decode register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_d     <= '0;
            instr_valid <= 1'b0;
        end else if (!stall) begin
            instr_d     <= instr;
            instr_valid <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decoder

    assign op    = instr_d[27:26];
    assign i_bit = instr_d[25];
    assign cmd   = instr_d[24:21];
    assign l_bit = instr_d[20];
    assign rn    = instr_d[19:16];
    assign rd    = instr_d[15:12];
    assign rm    = instr_d[3:0];

    always_comb begin
        ctrl     = '0;
        uses_rn  = 1'b0;
        uses_rm  = 1'b0;
        is_store = 1'b0;
        if (instr_valid) begin
            case (op)
                2'b00: begin
                    case (alu_op_t'(cmd))
                        ALU_AND, ALU_SUB, ALU_ADD, ALU_ORR, ALU_MOV: begin
                            ctrl.reg_write = (rd != NO_REG);
                            ctrl.alu_src   = i_bit;
                            ctrl.alu_op    = alu_op_t'(cmd);
                            uses_rn        = (alu_op_t'(cmd) != ALU_MOV);
                            uses_rm        = !i_bit;
                        end
                        default: ;
                    endcase
                end
                // address is base plus unsigned offset
                2'b01: begin
                    ctrl.alu_src = 1'b1;
                    ctrl.alu_op  = ALU_ADD;
                    uses_rn      = 1'b1;
                    if (l_bit) begin
                        ctrl.reg_write  = (rd != NO_REG);
                        ctrl.mem_to_reg = 1'b1;
                    end else begin
                        ctrl.mem_write = 1'b1;
                        is_store       = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // unused sources read as r15, which never matches a hazard
    assign rn_d = uses_rn ? rn : NO_REG;
    assign rm_d = is_store ? rd : (uses_rm ? rm : NO_REG);

    reg_file reg_file_i (
        .clk   (clk),
        .reset (reset),
        .ra1   (rn_d),
        .ra2   (rm_d),
        .wb    (wb),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    //////////////////////////////////////////////////////////////////////
    // decode-execute register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else begin
            id_ex.ctrl <= stall ? ctrl_t'('0) : ctrl;
            id_ex.rd1  <= rd1;
            id_ex.rd2  <= rd2;
            id_ex.imm  <= (op == 2'b01) ? instr_d[11:0] : {4'b0, instr_d[7:0]};
            id_ex.rn   <= rn_d;
            id_ex.rm   <= rm_d;
            id_ex.rd   <= rd;
        end
    end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module hazard_unit import core_pkg::*; (
    input  id_ex_t                 id_ex,
    input  logic [`REG_ADDR_W-1:0] rn_d,
    input  logic [`REG_ADDR_W-1:0] rm_d,
    input  ex_mem_t                ex_mem,
    input  wb_t                    wb,
    output fwd_sel_t               fwd_a,
    output fwd_sel_t               fwd_b,
    output logic                   stall
);

    localparam logic [`REG_ADDR_W-1:0] NO_REG = `REG_ADDR_W'(`NUM_REGS);

    // younger producer wins
    function automatic fwd_sel_t fwd_select(input logic [`REG_ADDR_W-1:0] src);
        fwd_sel_t sel;
        if (src == NO_REG) begin
            sel = FWD_NONE;
        end else if (ex_mem.reg_write && ex_mem.rd == src) begin
            sel = FWD_MEM;
        end else if (wb.reg_write && wb.rd == src) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = fwd_select(id_ex.rn);
        fwd_b = fwd_select(id_ex.rm);
    end

    // load result not ready until writeback
    assign stall = id_ex.ctrl.mem_to_reg && id_ex.rd != NO_REG &&
                   (id_ex.rd == rn_d || id_ex.rd == rm_d);

    // the stalling instruction is a load that writes its register
    always_comb begin
        a_stall_on_load: assert final (!stall ||
            (id_ex.ctrl.reg_write && !id_ex.ctrl.mem_write));
    end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module execute_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  id_ex_t   id_ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  wb_t      wb,
    output ex_mem_t  ex_mem
);

    logic [`DATA_W-1:0] src_a;
    logic [`DATA_W-1:0] src_b;
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] alu_result;

    //////////////////////////////////////////////////////////////////////
    // forwarding muxes

    always_comb begin
        case (fwd_a)
            FWD_MEM: src_a = ex_mem.alu_result;
            FWD_WB:  src_a = wb.result;
            default: src_a = id_ex.rd1;
        endcase
        case (fwd_b)
            FWD_MEM: src_b = ex_mem.alu_result;
            FWD_WB:  src_b = wb.result;
            default: src_b = id_ex.rd2;
        endcase
    end

    assign op_b = id_ex.ctrl.alu_src ? {{(`DATA_W-12){1'b0}}, id_ex.imm} : src_b;

    //////////////////////////////////////////////////////////////////////
    // alu

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_AND: alu_result = src_a & op_b;
            ALU_SUB: alu_result = src_a - op_b;
            ALU_ADD: alu_result = src_a + op_b;
            ALU_ORR: alu_result = src_a | op_b;
            ALU_MOV: alu_result = op_b;
            default: alu_result = '0;
        endcase
    end

    // store data is the forwarded register, never the offset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
            ex_mem.alu_result <= alu_result;
            ex_mem.write_data <= src_b;
            ex_mem.rd         <= id_ex.rd;
        end
    end

endmodule

// ==== hw/mem_wb_stage.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module mem_wb_stage import core_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  ex_mem_t            ex_mem,
    input  logic [`DATA_W-1:0] read_data,
    output wb_t                wb
);

    logic                   reg_write_q;
    logic                   mem_to_reg_q;
    logic [`REG_ADDR_W-1:0] rd_q;
    logic [`DATA_W-1:0]     load_q;
    logic [`DATA_W-1:0]     alu_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_q  <= 1'b0;
            mem_to_reg_q <= 1'b0;
            rd_q         <= '0;
            load_q       <= '0;
            alu_q        <= '0;
        end else begin
            reg_write_q  <= ex_mem.reg_write;
            mem_to_reg_q <= ex_mem.mem_to_reg;
            rd_q         <= ex_mem.rd;
            load_q       <= read_data;
            alu_q        <= ex_mem.alu_result;
        end
    end

    // writeback bus
    assign wb.reg_write = reg_write_q;
    assign wb.rd        = rd_q;
    assign wb.result    = mem_to_reg_q ? load_q : alu_q;

    // a memory op is either a load or a store
    a_load_store_excl: assert property (@(posedge clk) disable iff (reset)
        !(ex_mem.mem_write && ex_mem.mem_to_reg));

endmodule

// ==== hw/arm_core.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module arm_core import core_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [`DATA_W-1:0] instr,
    input  logic [`DATA_W-1:0] read_data,
    output logic [`DATA_W-1:0] instr_addr,
    output logic [`DATA_W-1:0] data_addr,
    output logic [`DATA_W-1:0] write_data,
    output logic               data_we
);

    logic                   stall;
    id_ex_t                 id_ex;
    ex_mem_t                ex_mem;
    wb_t                    wb;
    fwd_sel_t               fwd_a;
    fwd_sel_t               fwd_b;
    logic [`REG_ADDR_W-1:0] rn_d;
    logic [`REG_ADDR_W-1:0] rm_d;

    fetch_stage fetch_stage_i (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .pc    (instr_addr)
    );

    decode_stage decode_stage_i (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .instr (instr),
        .wb    (wb),
        .id_ex (id_ex),
        .rn_d  (rn_d),
        .rm_d  (rm_d)
    );

    hazard_unit hazard_unit_i (
        .id_ex  (id_ex),
        .rn_d   (rn_d),
        .rm_d   (rm_d),
        .ex_mem (ex_mem),
        .wb     (wb),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b),
        .stall  (stall)
    );

    execute_stage execute_stage_i (
        .clk    (clk),
        .reset  (reset),
        .id_ex  (id_ex),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b),
        .wb     (wb),
        .ex_mem (ex_mem)
    );

    mem_wb_stage mem_wb_stage_i (
        .clk       (clk),
        .reset     (reset),
        .ex_mem    (ex_mem),
        .read_data (read_data),
        .wb        (wb)
    );

    // data memory port from the memory stage
    assign data_addr  = ex_mem.alu_result;
    assign write_data = ex_mem.write_data;
    assign data_we    = ex_mem.mem_write;

endmodule

// ==== testbench/tb_arm_core.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module tb_arm_core;

    localparam int IMEM_WORDS = 512;
    localparam int MAX_STORES = 256;

    localparam logic [3:0] CMD_AND = 4'd0;
    localparam logic [3:0] CMD_SUB = 4'd2;
    localparam logic [3:0] CMD_ADD = 4'd4;
    localparam logic [3:0] CMD_ORR = 4'd12;
    localparam logic [3:0] CMD_MOV = 4'd13;

    logic               clk;
    logic               reset;
    logic [`DATA_W-1:0] instr;
    logic [`DATA_W-1:0] read_data;
    logic [`DATA_W-1:0] instr_addr;
    logic [`DATA_W-1:0] data_addr;
    logic [`DATA_W-1:0] write_data;
    logic               data_we;

    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] dmem [0:255];
    logic [31:0] model_regs [0:14];
    logic [31:0] model_mem [0:255];
    logic [31:0] exp_addr [0:MAX_STORES-1];
    logic [31:0] exp_data [0:MAX_STORES-1];
    logic [31:0] drain_addr;
    int          n_exp;
    int          prog_len;
    int          store_count = 0;
    bit          prog_ready;
    integer      seed;

    arm_core dut_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .read_data  (read_data),
        .instr_addr (instr_addr),
        .data_addr  (data_addr),
        .write_data (write_data),
        .data_we    (data_we)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // memories, both answer in the same cycle

    assign instr     = (instr_addr < 32'(IMEM_WORDS * 4)) ? imem[instr_addr[10:2]] : '0;
    assign read_data = dmem[data_addr[7:0]];

    always @(posedge clk) begin
        if (data_we) begin
            dmem[data_addr[7:0]] <= write_data;
            store_count          <= store_count + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // instruction encoders

    function automatic logic [31:0] dp_imm(input logic [3:0] cmd, input logic [3:0] rd,
                                          input logic [3:0] rn, input logic [7:0] imm);
        return {4'hE, 2'b00, 1'b1, cmd, 1'b0, rn, rd, 4'h0, imm};
    endfunction

    function automatic logic [31:0] dp_reg(input logic [3:0] cmd, input logic [3:0] rd,
                                          input logic [3:0] rn, input logic [3:0] rm);
        return {4'hE, 2'b00, 1'b0, cmd, 1'b0, rn, rd, 8'h00, rm};
    endfunction

    function automatic logic [31:0] mem_op(input logic load, input logic [3:0] rd,
                                          input logic [3:0] rn, input logic [11:0] offset);
        return {4'hE, 2'b01, 1'b0, 4'b1100, load, rn, rd, offset};
    endfunction

    function automatic logic [3:0] alu_cmd(input int k);
        logic [3:0] cmd;
        case (k)
            0: cmd = CMD_AND;
            1: cmd = CMD_SUB;
            2: cmd = CMD_ADD;
            3: cmd = CMD_ORR;
            default: cmd = CMD_MOV;
        endcase
        return cmd;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // sequential reference model

    // r15 is not a register and reads zero
    function automatic logic [31:0] model_read(input logic [3:0] idx);
        logic [31:0] value;
        value = (idx == 4'd15) ? 32'd0 : model_regs[idx];
        return value;
    endfunction

    task automatic model_step(input logic [31:0] w);
        logic [3:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic        known;
        rd    = w[15:12];
        a     = model_read(w[19:16]);
        b     = w[25] ? {24'd0, w[7:0]} : model_read(w[3:0]);
        res   = '0;
        known = 1'b1;
        if (w[27:26] == 2'b00) begin
            case (w[24:21])
                CMD_AND: res = a & b;
                CMD_SUB: res = a - b;
                CMD_ADD: res = a + b;
                CMD_ORR: res = a | b;
                CMD_MOV: res = b;
                default: known = 1'b0;
            endcase
            if (known && rd != 4'd15) begin
                model_regs[rd] = res;
            end
        end else if (w[27:26] == 2'b01) begin
            addr = a + {20'd0, w[11:0]};
            if (w[20]) begin
                if (rd != 4'd15) begin
                    model_regs[rd] = model_mem[addr[7:0]];
                end
            end else begin
                model_mem[addr[7:0]] = model_read(rd);
                exp_addr[8'(n_exp)]  = addr;
                exp_data[8'(n_exp)]  = model_read(rd);
                n_exp++;
            end
        end
    endtask

    task automatic emit(input logic [31:0] w);
        imem[9'(prog_len)] = w;
        model_step(w);
        prog_len++;
    endtask

    // zero word is AND r0, r0, r0
    task automatic emit_nops(input int count);
        for (int i = 0; i < count; i++) begin
            emit(32'h0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // programs

    task automatic build_directed();
        emit(dp_imm(CMD_MOV, 4'd1, 4'd0, 8'h5A));
        emit(dp_imm(CMD_MOV, 4'd2, 4'd0, 8'h3C));
        emit_nops(3);
        // every ALU op, immediate then register form
        for (int k = 0; k < 5; k++) begin
            emit(dp_imm(alu_cmd(k), 4'd3, 4'd1, 8'h0F));
            emit_nops(3);
            emit(mem_op(1'b0, 4'd3, 4'd0, 12'(16 + 2 * k)));
            emit(dp_reg(alu_cmd(k), 4'd3, 4'd1, 4'd2));
            emit_nops(3);
            emit(mem_op(1'b0, 4'd3, 4'd0, 12'(17 + 2 * k)));
        end
        // dependent chain through memory and writeback forwarding
        emit(dp_imm(CMD_ADD, 4'd4, 4'd1, 8'd1));
        emit(dp_reg(CMD_ADD, 4'd5, 4'd4, 4'd4));
        emit(dp_reg(CMD_SUB, 4'd6, 4'd5, 4'd4));
        emit(dp_reg(CMD_ORR, 4'd7, 4'd6, 4'd5));
        emit(mem_op(1'b0, 4'd7, 4'd0, 12'd40));
        emit(mem_op(1'b0, 4'd6, 4'd0, 12'd41));
        // load-use on ALU source, store data and load base
        emit(mem_op(1'b1, 4'd8, 4'd0, 12'd10));
        emit(dp_imm(CMD_ADD, 4'd9, 4'd8, 8'd7));
        emit(mem_op(1'b0, 4'd9, 4'd0, 12'd50));
        emit(mem_op(1'b1, 4'd11, 4'd0, 12'd20));
        emit(mem_op(1'b0, 4'd11, 4'd0, 12'd51));
        emit(mem_op(1'b1, 4'd12, 4'd0, 12'd5));
        emit(mem_op(1'b1, 4'd13, 4'd12, 12'd3));
        emit(mem_op(1'b0, 4'd13, 4'd0, 12'd52));
        // store data written just before
        emit(dp_reg(CMD_ADD, 4'd9, 4'd1, 4'd2));
        emit(mem_op(1'b0, 4'd9, 4'd0, 12'd53));
        emit(dp_imm(CMD_SUB, 4'd10, 4'd9, 8'd3));
        emit_nops(1);
        emit(mem_op(1'b0, 4'd10, 4'd0, 12'd54));
        // r15 targets and undefined encodings
        emit(dp_imm(CMD_MOV, 4'd15, 4'd0, 8'h77));
        emit(mem_op(1'b0, 4'd15, 4'd0, 12'd60));
        emit(dp_imm(CMD_ADD, 4'd15, 4'd1, 8'd1));
        emit(mem_op(1'b1, 4'd15, 4'd0, 12'd2));
        emit(mem_op(1'b0, 4'd15, 4'd0, 12'd61));
        emit(dp_imm(4'd1, 4'd1, 4'd2, 8'hFF));
        emit(dp_reg(4'd15, 4'd2, 4'd0, 4'd1));
        emit({4'hE, 2'b10, 1'b0, CMD_MOV, 1'b0, 4'd0, 4'd1, 12'h0FF});
        emit({4'hE, 2'b11, 1'b1, CMD_ADD, 1'b0, 4'd1, 4'd2, 12'h011});
        emit_nops(3);
        emit(mem_op(1'b0, 4'd15, 4'd0, 12'd62));
        emit(mem_op(1'b0, 4'd1, 4'd15, 12'd63));
        emit(mem_op(1'b0, 4'd2, 4'd15, 12'd64));
    endtask

    task automatic build_random(input int count);
        int          kind;
        logic [3:0]  rd;
        logic [3:0]  rn;
        logic [3:0]  rm;
        logic [31:0] limit;
        for (int k = 0; k < count; k++) begin
            kind = {$random(seed)} % 8;
            rd   = 4'({$random(seed)} % 8);
            rn   = 4'({$random(seed)} % 8);
            rm   = 4'({$random(seed)} % 8);
            if (kind < 3) begin
                emit(dp_imm(alu_cmd({$random(seed)} % 5), rd, rn, 8'($random(seed))));
            end else if (kind < 5) begin
                emit(dp_reg(alu_cmd({$random(seed)} % 5), rd, rn, rm));
            end else begin
                // a base too large for the memory falls back to r15
                if (model_regs[rn] > 32'd255) begin
                    rn = 4'd15;
                end
                limit = 32'd256 - model_read(rn);
                emit(mem_op(kind == 5, rd, rn, 12'({$random(seed)} % limit)));
            end
        end
        // final register state of r0 to r7
        for (int r = 0; r < 8; r++) begin
            emit(mem_op(1'b0, 4'(r), 4'd15, 12'(100 + r)));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks

    a_store_order: assert property (@(posedge clk) disable iff (reset)
        data_we |-> store_count < n_exp && data_addr == exp_addr[8'(store_count)] &&
                    write_data == exp_data[8'(store_count)])
        else begin
            $display("Error at %0t: store %0d wrote %h to %0d, expected %h to %0d",
                     $time, $sampled(store_count), $sampled(write_data),
                     $sampled(data_addr), exp_data[8'($sampled(store_count))],
                     exp_addr[8'($sampled(store_count))]);
            $display("RESULT: FAIL");
            $fatal(1, "store mismatch");
        end

    a_quiet_in_reset: assert property (@(posedge clk) reset |-> !data_we)
        else begin
            $display("a store was issued during reset at %0t", $time);
            $display("RESULT: FAIL");
            $fatal(1, "store during reset");
        end

    // the pc moves one word per cycle, or holds for a load-use bubble
    a_pc_step: assert property (@(posedge clk) disable iff (reset)
        instr_addr == $past(instr_addr) ||
        instr_addr == $past(instr_addr) + 32'(`PC_STEP))
        else begin
            $display("Error at %0t: pc stepped to %h", $time, $sampled(instr_addr));
            $display("RESULT: FAIL");
            $fatal(1, "pc step mismatch");
        end

    initial begin
        wait (prog_ready);
        repeat (10 * prog_len + 50) @(posedge clk);
        $display("timeout: the program did not finish within %0d cycles", 10 * prog_len + 50);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        seed     = 84;
        n_exp    = 0;
        prog_len = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[9'(i)] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[8'(i)]      <= 32'(i * 3);
            model_mem[8'(i)] = 32'(i * 3);
        end
        for (int i = 0; i < 15; i++) begin
            model_regs[4'(i)] = '0;
        end
        build_directed();
        build_random(60);
        drain_addr = 32'((prog_len + 8) * 4);
        prog_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        // run until the last instruction has left the pipeline
        while (instr_addr < drain_addr) begin
            @(posedge clk);
            #1;
        end
        if (store_count == n_exp) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("wrong number of stores: saw %0d, expected %0d", store_count, n_exp);
            $display("RESULT: FAIL");
            $fatal(1, "store count mismatch");
        end
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/core_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/arm_core.sv
testbench/tb_arm_core.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' list.f) hw/core_params.svh

.PHONY: run clean

run: obj_dir/Vtb_arm_core
	./obj_dir/Vtb_arm_core | tee sim.log
	grep -q "RESULT: PASS" sim.log

obj_dir/Vtb_arm_core: list.f $(SRCS)
	verilator --binary --timing --assert -f list.f --top-module tb_arm_core

clean:
	rm -rf obj_dir sim.log
